/* source/mips_exec_pkg.sv */
package mips_exec_pkg;

    localparam int word_bits = 32;
    localparam int shamt_bits = 5;
    localparam int muldiv_steps = 32;                       // Iterations per multiply or divide
    localparam int step_cnt_bits = $clog2(muldiv_steps);

    typedef logic [word_bits-1:0] word_t;
    typedef logic [shamt_bits-1:0] shamt_t;
    typedef logic [step_cnt_bits-1:0] step_cnt_t;

    // Function codes as issued by the decoder
    typedef enum logic [4:0] {
        op_and       = 5'b00000,
        op_or        = 5'b00001,
        op_xor       = 5'b00010,
        op_addu      = 5'b00011,
        op_subu      = 5'b00100,
        op_sltu      = 5'b00101,
        op_slt       = 5'b00110,
        op_multu     = 5'b00111,
        op_mult      = 5'b01000,
        op_shift_ll  = 5'b01001,
        op_shift_llv = 5'b01010,
        op_shift_ra  = 5'b01011,
        op_shift_rl  = 5'b01100,
        op_shift_rav = 5'b01101,
        op_shift_rlv = 5'b01110,
        op_div       = 5'b01111,
        op_divu      = 5'b10000,
        op_mfhi      = 5'b10001,
        op_mflo      = 5'b10010,
        op_bltz      = 5'b10011,
        op_bgtz      = 5'b10100,
        op_bgez      = 5'b10101,
        op_bne       = 5'b10110,
        op_blez      = 5'b10111,
        op_jr        = 5'b11000
    } alu_op_e;

    typedef struct packed {
        alu_op_e op;
        word_t   a;
        word_t   b;
        shamt_t  shamt;                                     // From instr[10:6]
        word_t   imm;                                       // Extended upstream
        logic    use_imm;                                   // Replaces b
    } exec_req_t;

    typedef struct packed {
        word_t y;
        logic  zero;
    } exec_res_t;

    typedef struct packed {
        alu_op_e op;
        word_t   a;
        word_t   b;
    } muldiv_cmd_t;

endpackage

/* source/exec_issue.sv */
module exec_issue (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       in_valid,
    input  mips_exec_pkg::exec_req_t   req,
    input  logic                       muldiv_busy,
    output logic                       busy,
    output logic                       alu_valid,
    output mips_exec_pkg::exec_req_t   alu_req,
    output logic                       muldiv_start,
    output mips_exec_pkg::muldiv_cmd_t muldiv_cmd
);
    import mips_exec_pkg::*;

    logic      accept;
    logic      is_muldiv;
    word_t     b_sel;
    exec_req_t req_sel;

    // Strobes arriving while busy are dropped
    assign accept = in_valid && !busy;

    assign b_sel = req.use_imm ? req.imm : req.b;

    always_comb begin
        req_sel = req;
        req_sel.b = b_sel;                                  // Immediate already applied
    end

    // HI/LO writers go to the sequential unit
    always_comb begin
        case (req.op)
            op_mult, op_multu, op_div, op_divu: begin
                is_muldiv = 1'b1;
            end
            default: begin
                is_muldiv = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            alu_valid <= 1'b0;
            muldiv_start <= 1'b0;
        end else begin
            alu_valid <= accept && !is_muldiv;
            muldiv_start <= accept && is_muldiv;            // Single cycle strobe
        end
    end

    always_ff @(posedge clk) begin
        if (accept && !is_muldiv) begin
            alu_req <= req_sel;
        end
        if (accept && is_muldiv) begin
            muldiv_cmd.op <= req.op;
            muldiv_cmd.a <= req.a;
            muldiv_cmd.b <= b_sel;
        end
    end

    // Covers the gap before the unit reports busy itself
    assign busy = muldiv_start || muldiv_busy;

endmodule

/* source/alu.sv */
module alu (
    input  mips_exec_pkg::exec_req_t alu_req,
    input  mips_exec_pkg::word_t     hi,
    input  mips_exec_pkg::word_t     lo,
    output mips_exec_pkg::word_t     y
);
    import mips_exec_pkg::*;

    word_t  a;
    word_t  b;
    shamt_t shamt;
    shamt_t var_sh;

    // Zero when the branch is taken, one otherwise
    function automatic word_t branch_word(input logic taken);
        word_t w;
        w = taken ? word_t'(0) : word_t'(1);
        return w;
    endfunction

    assign a = alu_req.a;
    assign b = alu_req.b;
    assign shamt = alu_req.shamt;
    assign var_sh = a[shamt_bits-1:0];                      // Only the low bits count

    always_comb begin
        case (alu_req.op)
            op_and: begin
                y = a & b;
            end
            op_or: begin
                y = a | b;
            end
            op_xor: begin
                y = a ^ b;
            end
            op_addu: begin
                y = a + b;
            end
            op_subu: begin
                y = a - b;
            end
            op_sltu: begin
                y = word_t'(a < b);
            end
            op_slt: begin
                y = word_t'($signed(a) < $signed(b));
            end
            op_shift_ll: begin
                y = b << shamt;
            end
            op_shift_llv: begin
                y = b << var_sh;
            end
            op_shift_ra: begin
                y = $signed(b) >>> shamt;                   // Sign fill
            end
            op_shift_rl: begin
                y = b >> shamt;
            end
            op_shift_rav: begin
                y = $signed(b) >>> var_sh;
            end
            op_shift_rlv: begin
                y = b >> var_sh;
            end
            op_mfhi: begin
                y = hi;
            end
            op_mflo: begin
                y = lo;
            end
            op_bltz: begin
                y = branch_word(a[word_bits-1]);
            end
            op_bgtz: begin
                y = branch_word(!a[word_bits-1] && (a != '0));
            end
            op_bgez: begin
                y = branch_word(!a[word_bits-1]);
            end
            op_bne: begin
                y = branch_word(a != b);
            end
            op_blez: begin
                y = branch_word(a[word_bits-1] || (a == '0));
            end
            op_jr: begin
                y = a;                                      // Target passes straight through
            end
            default: begin
                y = '0;                                     // Includes the HI/LO writers
            end
        endcase
    end

endmodule

/* source/muldiv_unit.sv */
module muldiv_unit (
    input  logic                       clk,
    input  logic                       reset,
    input  logic                       start,
    input  mips_exec_pkg::muldiv_cmd_t cmd,
    output logic                       busy,
    output mips_exec_pkg::word_t       hi,
    output mips_exec_pkg::word_t       lo
);
    import mips_exec_pkg::*;

    typedef enum logic [1:0] {
        st_idle,
        st_run,
        st_fix_sign
    } md_state_e;

    md_state_e state;
    step_cnt_t count;

    logic  cmd_signed;
    logic  a_neg;
    logic  b_neg;
    word_t a_mag;
    word_t b_mag;

    word_t hi_acc;                                          // Partial product high or remainder
    word_t lo_acc;                                          // Multiplier or quotient bits
    word_t mag_b;
    logic  is_div;
    logic  neg_res;
    logic  neg_rem;

    logic [word_bits:0] mul_sum;
    logic [word_bits:0] div_shift;
    logic [word_bits:0] div_diff;
    logic               div_ge;

    // Magnitudes for the signed forms
    assign cmd_signed = (cmd.op == op_mult) || (cmd.op == op_div);
    assign a_neg = cmd_signed && cmd.a[word_bits-1];
    assign b_neg = cmd_signed && cmd.b[word_bits-1];
    assign a_mag = a_neg ? -cmd.a : cmd.a;
    assign b_mag = b_neg ? -cmd.b : cmd.b;

    // One shift-add or restoring step
    always_comb begin
        mul_sum = {1'b0, hi_acc} + (lo_acc[0] ? {1'b0, mag_b} : '0);
        div_shift = {hi_acc, lo_acc[word_bits-1]};
        div_diff = div_shift - {1'b0, mag_b};
        div_ge = div_shift >= {1'b0, mag_b};
    end

    always_ff @(posedge clk) begin
        if (!reset) begin
            state <= st_idle;
            count <= '0;
            hi <= '0;
            lo <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (start) begin
                        state <= st_run;
                        count <= step_cnt_t'(muldiv_steps - 1);
                    end
                end
                st_run: begin
                    count <= count - 1'b1;
                    if (count == '0) begin
                        state <= st_fix_sign;
                    end
                end
                st_fix_sign: begin
                    state <= st_idle;
                    if (is_div) begin
                        lo <= neg_res ? -lo_acc : lo_acc;   // Truncates toward zero
                        hi <= neg_rem ? -hi_acc : hi_acc;   // Sign of the dividend
                    end else begin
                        {hi, lo} <= neg_res ? -{hi_acc, lo_acc} : {hi_acc, lo_acc};
                    end
                end
                default: begin
                    state <= st_idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && start) begin
            hi_acc <= '0;
            lo_acc <= a_mag;
            mag_b <= b_mag;
            is_div <= (cmd.op == op_div) || (cmd.op == op_divu);
            neg_res <= a_neg ^ b_neg;
            neg_rem <= a_neg;
        end else if (state == st_run) begin
            if (is_div) begin
                hi_acc <= div_ge ? div_diff[word_bits-1:0] : div_shift[word_bits-1:0];
                lo_acc <= {lo_acc[word_bits-2:0], div_ge};
            end else begin
                hi_acc <= mul_sum[word_bits:1];
                lo_acc <= {mul_sum[0], lo_acc[word_bits-1:1]};
            end
        end
    end

    assign busy = (state != st_idle);

endmodule

/* source/exec_result.sv */
module exec_result (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     alu_valid,
    input  mips_exec_pkg::word_t     alu_y,
    output logic                     out_valid,
    output mips_exec_pkg::exec_res_t res
);

    logic y_is_zero;

    // Flag for the branch logic
    assign y_is_zero = (alu_y == '0);

    always_ff @(posedge clk) begin
        if (!reset) begin
            out_valid <= 1'b0;
        end else begin
            out_valid <= alu_valid;                         // One pulse per ALU item
        end
    end

    always_ff @(posedge clk) begin
        if (alu_valid) begin
            res.y <= alu_y;
            res.zero <= y_is_zero;
        end
    end

endmodule

/* source/mips_exec.sv */
module mips_exec (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    input  mips_exec_pkg::exec_req_t req,
    output logic                     busy,
    output logic                     out_valid,
    output mips_exec_pkg::exec_res_t res
);
    import mips_exec_pkg::*;

    logic        alu_valid;
    exec_req_t   alu_req;
    logic        muldiv_start;
    muldiv_cmd_t muldiv_cmd;
    logic        muldiv_busy;
    word_t       hi;
    word_t       lo;
    word_t       alu_y;

    exec_issue i_exec_issue (
        .clk          (clk),
        .reset        (reset),
        .in_valid     (in_valid),
        .req          (req),
        .muldiv_busy  (muldiv_busy),
        .busy         (busy),
        .alu_valid    (alu_valid),
        .alu_req      (alu_req),
        .muldiv_start (muldiv_start),
        .muldiv_cmd   (muldiv_cmd)
    );

    alu i_alu (
        .alu_req (alu_req),
        .hi      (hi),
        .lo      (lo),
        .y       (alu_y)
    );

    muldiv_unit i_muldiv_unit (
        .clk   (clk),
        .reset (reset),
        .start (muldiv_start),
        .cmd   (muldiv_cmd),
        .busy  (muldiv_busy),
        .hi    (hi),
        .lo    (lo)
    );

    exec_result i_exec_result (
        .clk       (clk),
        .reset     (reset),
        .alu_valid (alu_valid),
        .alu_y     (alu_y),
        .out_valid (out_valid),
        .res       (res)
    );

endmodule

/* tests/exec_checker.sv */
module exec_checker (
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     in_valid,
    input  mips_exec_pkg::exec_req_t req,
    input  logic                     busy,
    input  logic                     out_valid,
    input  mips_exec_pkg::exec_res_t res,
    output int                       check_count,
    output int                       error_count,
    output int                       pending
);
    timeunit 1ns;
    timeprecision 100ps;
    import mips_exec_pkg::*;

    word_t model_hi;
    word_t model_lo;
    word_t exp_y_q[$];                                      // Expected words in issue order
    int    exp_cycle_q[$];                                  // Accepting cycle of each
    word_t exp_y;
    int    exp_cycle;
    int    cycle;
    logic  busy_watch;
    int    busy_len;

    // MIPS semantics of every ALU-class function code
    function automatic word_t expected_y(input exec_req_t r, input word_t hi_v, input word_t lo_v);
        word_t b;
        logic  taken;
        b = r.use_imm ? r.imm : r.b;
        taken = 1'b0;
        case (r.op)
            op_and:       return r.a & b;
            op_or:        return r.a | b;
            op_xor:       return r.a ^ b;
            op_addu:      return r.a + b;
            op_subu:      return r.a - b;
            op_sltu:      return {31'b0, r.a < b};
            op_slt:       return {31'b0, $signed(r.a) < $signed(b)};
            op_shift_ll:  return b << r.shamt;
            op_shift_llv: return b << r.a[4:0];
            op_shift_rl:  return b >> r.shamt;
            op_shift_rlv: return b >> r.a[4:0];
            op_shift_ra:  return $signed(b) >>> r.shamt;
            op_shift_rav: return $signed(b) >>> r.a[4:0];
            op_mfhi:      return hi_v;
            op_mflo:      return lo_v;
            op_jr:        return r.a;
            op_bltz:      taken = $signed(r.a) < 0;
            op_bgtz:      taken = $signed(r.a) > 0;
            op_bgez:      taken = $signed(r.a) >= 0;
            op_blez:      taken = $signed(r.a) <= 0;
            op_bne:       taken = r.a != b;
            default:      return '0;
        endcase
        return taken ? '0 : 32'd1;                          // Taken branch gives zero
    endfunction

    function automatic logic writes_hilo(input alu_op_e op);
        return op == op_mult || op == op_multu || op == op_div || op == op_divu;
    endfunction

    task automatic apply_hilo(input exec_req_t r);
        word_t       b;
        longint      sa;
        longint      sb;
        logic [63:0] full;
        b = r.use_imm ? r.imm : r.b;
        sa = longint'($signed(r.a));
        sb = longint'($signed(b));
        case (r.op)
            op_mult:  full = sa * sb;
            op_multu: full = {32'b0, r.a} * {32'b0, b};
            op_div:   full = {32'(sa % sb), 32'(sa / sb)};  // Remainder follows the dividend
            default:  full = {r.a % b, r.a / b};
        endcase
        {model_hi, model_lo} = full;
    endtask

    task automatic report_mismatch(input string msg);
        error_count++;
        $display("CHECK FAILED at %0d ns: %s", $time, msg);
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            model_hi = '0;
            model_lo = '0;
            exp_y_q.delete();
            exp_cycle_q.delete();
            pending = 0;
            cycle = 0;
            busy_watch = 1'b0;
        end else begin
            cycle++;
            if (busy_watch && busy) begin
                busy_len++;
            end else if (busy_watch) begin
                busy_watch = 1'b0;
                check_count++;
                if (busy_len != muldiv_steps + 2) begin
                    report_mismatch($sformatf("busy lasted %0d cycles, expected %0d",
                                              busy_len, muldiv_steps + 2));
                end
            end else if (busy) begin
                report_mismatch("busy high with no multiply or divide in progress");
            end
            if (out_valid && exp_y_q.size() == 0) begin
                error_count++;
                $display("Result appeared at %0d ns with no request outstanding", $time);
            end else if (out_valid) begin
                exp_y = exp_y_q.pop_front();
                exp_cycle = exp_cycle_q.pop_front();
                pending--;
                check_count++;
                if (res.y !== exp_y || res.zero !== (exp_y == '0) || cycle != exp_cycle + 2) begin
                    report_mismatch($sformatf("got y %h zero %b at cycle %0d, expected %h %b at %0d",
                                              res.y, res.zero, cycle, exp_y, exp_y == '0,
                                              exp_cycle + 2));
                end
            end
            if (in_valid && !busy && writes_hilo(req.op)) begin
                apply_hilo(req);
                busy_watch = 1'b1;
                busy_len = 0;
            end else if (in_valid && !busy) begin
                exp_y_q.push_back(expected_y(req, model_hi, model_lo));
                exp_cycle_q.push_back(cycle);
                pending++;
            end
        end
    end

endmodule

/* tests/tb_mips_exec.sv */
module tb_mips_exec;
    timeunit 1ns;
    timeprecision 100ps;
    import mips_exec_pkg::*;

    localparam int clk_period = 20;
    localparam int seed = 18345;
    localparam int n_requests = 168;                        // Sum over all tests below
    localparam int timeout_cycles = n_requests * (muldiv_steps + 4) + 200;

    logic      clk = 1'b0;
    logic      reset = 1'b0;
    logic      in_valid = 1'b0;
    exec_req_t req = '0;
    logic      busy;
    logic      out_valid;
    exec_res_t res;
    int        check_count;
    int        error_count;
    int        pending;
    int        checks_before = 0;
    int        errors_before = 0;

    always #(clk_period / 2) clk = ~clk;

    mips_exec i_mips_exec (
        .clk       (clk),
        .reset     (reset),
        .in_valid  (in_valid),
        .req       (req),
        .busy      (busy),
        .out_valid (out_valid),
        .res       (res)
    );

    exec_checker i_checker (
        .clk         (clk),
        .reset       (reset),
        .in_valid    (in_valid),
        .req         (req),
        .busy        (busy),
        .out_valid   (out_valid),
        .res         (res),
        .check_count (check_count),
        .error_count (error_count),
        .pending     (pending)
    );

    // Codes first_code .. first_code+n_codes-1, zero and equal operands now and then
    function automatic exec_req_t random_req(input int first_code, input int n_codes);
        exec_req_t   r;
        logic [15:0] half;
        half = 16'($urandom());
        r.op = alu_op_e'(5'(first_code + $urandom() % n_codes));
        r.a = ($urandom() % 4 == 0) ? '0 : $urandom();
        r.b = ($urandom() % 4 == 0) ? r.a : $urandom();
        if ($urandom() % 4 == 0) r.b[word_bits-1] = ~r.a[word_bits-1];
        r.shamt = shamt_t'($urandom());
        r.imm = {{16{half[15]}}, half};
        r.use_imm = ($urandom() % 3 == 0);
        return r;
    endfunction

    // Holds the strobe until the DUT can take it
    task automatic send_req(input exec_req_t r);
        @(posedge clk);
        in_valid <= 1'b1;
        req <= r;
        @(negedge clk);
        while (busy) @(negedge clk);
    endtask

    task automatic finish_test(input string name);
        @(posedge clk);
        in_valid <= 1'b0;
        @(negedge clk);
        while (pending != 0 || busy) @(negedge clk);
        $display("%s: %0d checks, %0d errors", name, check_count - checks_before,
                 error_count - errors_before);
        checks_before = check_count;
        errors_before = error_count;
    endtask

    task automatic drive_random(input string name, input int first_code, input int n_codes,
                                input int count);
        for (int i = 0; i < count; i++) send_req(random_req(first_code, n_codes));
        finish_test(name);
    endtask

    // Every sign combination, each result read back through MFHI and MFLO
    task automatic check_hilo_ops(input string name, input alu_op_e s_op, input alu_op_e u_op);
        exec_req_t r;
        for (int i = 0; i < 8; i++) begin
            r = random_req(int'(op_and), 1);
            r.op = i[2] ? u_op : s_op;
            r.use_imm = 1'b0;
            r.a = $urandom() & 32'h7fff_ffff;
            r.b = (s_op == op_div) ? $urandom() % 5000 + 1 : $urandom() & 32'h7fff_ffff;
            if (i[0]) r.a = -r.a;
            if (i[1]) r.b = -r.b;
            send_req(r);
            r.op = op_mfhi;
            send_req(r);
            r.op = op_mflo;
            send_req(r);
        end
        finish_test(name);
    endtask

    task automatic reset_and_burst();
        exec_req_t r;
        r = random_req(int'(op_and), 1);
        r.op = op_mfhi;
        send_req(r);
        r.op = op_mflo;
        send_req(r);
        for (int i = 0; i < 16; i++) send_req(random_req(int'(op_and), 7));
        finish_test("reset_and_burst");
    endtask

    initial begin
        void'($urandom(seed));
        repeat (5) @(posedge clk);
        reset <= 1'b1;
        reset_and_burst();
        drive_random("logic_arith", int'(op_and), 7, 40);
        drive_random("shifts", int'(op_shift_ll), 6, 32);
        drive_random("branch_jr", int'(op_bltz), 6, 30);
        check_hilo_ops("multiply", op_mult, op_multu);
        check_hilo_ops("divide", op_div, op_divu);
        $display("All tests done: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (timeout_cycles) @(posedge clk);
        $display("Timed out after %0d cycles before all tests finished", timeout_cycles);
        $display("FAIL: see errors above");
        $finish;
    end

endmodule

/* mips_exec.f */
source/mips_exec_pkg.sv
source/exec_issue.sv
source/alu.sv
source/muldiv_unit.sv
source/exec_result.sv
source/mips_exec.sv
tests/exec_checker.sv
tests/tb_mips_exec.sv

/* Makefile */
SIM := obj_dir/Vtb_mips_exec

.PHONY: run clean

run: $(SIM)
	./$(SIM) > sim.log || true
	cat sim.log
	grep -qx "PASS: all tests" sim.log

$(SIM): mips_exec.f $(wildcard source/*.sv tests/*.sv)
	verilator --binary --timing -f mips_exec.f --top-module tb_mips_exec -o Vtb_mips_exec

clean:
	rm -rf obj_dir sim.log
